// File: hw/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    localparam int ADDR_BITS        = 32;
    localparam int LINE_OFFSET_BITS = 6;   // 64 bytes per line
    localparam int BANK_BITS        = 3;   // address bits 5..3
    localparam int NUM_BANKS        = 8;
    localparam int WORD_BITS        = 64;
    localparam int LINE_BITS        = NUM_BANKS * WORD_BITS;
    localparam int NUM_WAYS         = 2;

    // set count the tag entry is sized for
    localparam int TAG_SETS = 64;

    // tag width left over once index and line offset are taken out
    function automatic int tag_bits(input int num_sets);
        return ADDR_BITS - $clog2(num_sets) - LINE_OFFSET_BITS;
    endfunction

    localparam int TAG_BITS = tag_bits(TAG_SETS);

    typedef logic [NUM_WAYS-1:0]  way_oh_t;
    typedef logic [NUM_BANKS-1:0] bank_oh_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_CACHE,
        READ_CACHE,
        WRITE_MEM,     // dirty victim out
        READ_MEM,      // line fetch
        REFILL_READ,
        REFILL_WRITE
    } ctrl_state_t;

endpackage

// File: hw/dcache_bus_pkg.sv
package dcache_bus_pkg;

    import dcache_cfg_pkg::*;

    // shared by the front port and the memory port
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01
    } bus_op_t;

    // front request, one bank word with a bit mask
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        bus_op_t              op;
        word_t                wdata;
        word_t                wmask;   // one bit per data bit
    } cpu_req_t;

    // memory request, always a whole line
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;    // line aligned
        bus_op_t              op;
        line_t                wdata;
    } mem_req_t;

endpackage

// File: hw/dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array
    import dcache_cfg_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                        clock,
    input  logic                        reset_n,
    // read both ways of one set
    input  logic                        rd_en,
    input  logic [$clog2(NUM_SETS)-1:0] rd_index,
    output tag_entry_t [NUM_WAYS-1:0]   rd_entries,
    // rewrite one way of one set
    input  logic                        wr_en,
    input  logic [$clog2(NUM_SETS)-1:0] wr_index,
    input  way_oh_t                     wr_way,
    input  tag_entry_t                  wr_entry
);

    // kept in flops so that every valid bit clears on reset
    tag_entry_t [NUM_WAYS-1:0] entries [NUM_SETS];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                entries[s] <= '0;
            end
        end else if (wr_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr_way[w]) begin
                    entries[wr_index][w] <= wr_entry;
                end
            end
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_entries <= '0;
        end else if (rd_en) begin
            rd_entries <= entries[rd_index];
        end
    end

endmodule

// File: hw/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array
    import dcache_cfg_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                        clock,
    input  logic                        en,
    input  logic                        we,
    input  way_oh_t                     way,
    input  bank_oh_t                    banks,
    input  logic [$clog2(NUM_SETS)-1:0] index,
    input  line_t                       wdata,
    input  line_t                       wmask,   // per bit, within enabled banks
    output line_t                       rdata
);

    // one word RAM per way and bank
    word_t mem [NUM_WAYS][NUM_BANKS][NUM_SETS];

    always_ff @(posedge clock) begin
        if (en && we) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    if (way[w] && banks[b]) begin
                        mem[w][b][index] <=
                            (mem[w][b][index] & ~wmask[b*WORD_BITS +: WORD_BITS])
                            | (wdata[b*WORD_BITS +: WORD_BITS]
                               & wmask[b*WORD_BITS +: WORD_BITS]);
                    end
                end
            end
        end
    end

    // whole line of the selected way, held until the next read
    always_ff @(posedge clock) begin
        if (en && !we) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way[w]) begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        rdata[b*WORD_BITS +: WORD_BITS] <= mem[w][b][index];
                    end
                end
            end
        end
    end

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                        clock,
    input  logic                        reset_n,
    // front port
    input  logic                        req_valid,
    input  cpu_req_t                    req,
    output logic                        req_ready,
    output logic                        done,
    output word_t                       rdata,
    // memory port
    output logic                        mem_valid,
    output mem_req_t                    mem_req,
    input  logic                        mem_ready,
    input  logic                        mem_done,
    input  line_t                       mem_rdata,
    // tag array
    output logic                        tag_rd_en,
    output logic [$clog2(NUM_SETS)-1:0] tag_rd_index,
    input  tag_entry_t [NUM_WAYS-1:0]   tag_rd_entries,
    output logic                        tag_wr_en,
    output logic [$clog2(NUM_SETS)-1:0] tag_wr_index,
    output way_oh_t                     tag_wr_way,
    output tag_entry_t                  tag_wr_entry,
    // data array
    output logic                        data_en,
    output logic                        data_we,
    output way_oh_t                     data_way,
    output bank_oh_t                    data_banks,
    output logic [$clog2(NUM_SETS)-1:0] data_index,
    output line_t                       data_wdata,
    output line_t                       data_wmask,
    input  line_t                       data_rdata
);

    localparam int IDX_BITS = $clog2(NUM_SETS);

    ctrl_state_t          state;
    ctrl_state_t          next_state;
    cpu_req_t             req_q;
    line_t                fill_line;     // fetched line, kept for refill
    way_oh_t              way_q;         // hit way or victim way
    logic                 hit_q;
    logic [7:0]           lfsr;

    logic [IDX_BITS-1:0]  req_index;
    logic [BANK_BITS-1:0] req_bank;
    bank_oh_t             bank_oh;
    logic [TAG_BITS-1:0]  req_tag;
    logic                 is_write;
    line_t                store_data_line;
    line_t                store_mask_line;
    line_t                merge_mask;
    way_oh_t              way_valid;
    way_oh_t              way_dirty;
    way_oh_t              hit_way;
    way_oh_t              rand_way;
    way_oh_t              victim_way;
    logic                 hit;
    logic                 victim_dirty;
    tag_entry_t           victim_entry;
    logic [ADDR_BITS-1:0] victim_addr;
    logic [ADDR_BITS-1:0] fill_addr;
    logic                 mem_issue;
    mem_req_t             mem_next;

    // lowest set bit wins
    function automatic way_oh_t first_one(input way_oh_t v);
        way_oh_t oh;
        oh = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (v[w]) begin
                oh = way_oh_t'(1) << w;
            end
        end
        return oh;
    endfunction

    function automatic word_t bank_word(input line_t line, input logic [BANK_BITS-1:0] bank);
        return line[bank*WORD_BITS +: WORD_BITS];
    endfunction

    assign req_index = req_q.addr[LINE_OFFSET_BITS +: IDX_BITS];
    assign req_bank  = req_q.addr[LINE_OFFSET_BITS-1 -: BANK_BITS];
    assign bank_oh   = bank_oh_t'(1) << req_bank;
    assign req_tag   = TAG_BITS'(req_q.addr >> (LINE_OFFSET_BITS + IDX_BITS));
    assign is_write  = (req_q.op == OP_WRITE);

    // store word and mask placed in their bank
    always_comb begin
        store_data_line = '0;
        store_mask_line = '0;
        store_data_line[req_bank*WORD_BITS +: WORD_BITS] = req_q.wdata;
        store_mask_line[req_bank*WORD_BITS +: WORD_BITS] = req_q.wmask;
    end

    assign merge_mask = is_write ? store_mask_line : '0;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_valid[w] = tag_rd_entries[w].valid;
            way_dirty[w] = tag_rd_entries[w].dirty;
            hit_way[w]   = tag_rd_entries[w].valid && (tag_rd_entries[w].tag == req_tag);
        end
    end

    assign hit      = |hit_way;
    assign rand_way = way_oh_t'(1) << lfsr[$clog2(NUM_WAYS)-1:0];

    // invalid way first, then a clean one, random only when all are dirty
    assign victim_way = !(&way_valid) ? first_one(~way_valid) :
                        !(&way_dirty) ? first_one(~way_dirty) : rand_way;
    assign victim_dirty = |(victim_way & way_valid & way_dirty);

    // tag entries stay put until the next accepted request
    always_comb begin
        victim_entry = tag_rd_entries[0];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_q[w]) begin
                victim_entry = tag_rd_entries[w];
            end
        end
    end

    assign victim_addr = (ADDR_BITS'(victim_entry.tag) << (LINE_OFFSET_BITS + IDX_BITS))
                       | (ADDR_BITS'(req_index) << LINE_OFFSET_BITS);
    assign fill_addr   = {req_q.addr[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            hit_q <= 1'b0;
            way_q <= '0;
            lfsr  <= 8'hff;
        end else begin
            state <= next_state;
            lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (state == LOOKUP) begin
                hit_q <= hit;
                way_q <= hit ? hit_way : victim_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == READ_MEM && mem_done) begin
            fill_line <= mem_rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:         if (req_valid) next_state = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    next_state = is_write ? WRITE_CACHE : READ_CACHE;
                end else begin
                    next_state = victim_dirty ? READ_CACHE : READ_MEM;
                end
            end
            WRITE_CACHE:  next_state = IDLE;
            READ_CACHE:   next_state = hit_q ? IDLE : WRITE_MEM;
            WRITE_MEM:    if (mem_done) next_state = READ_MEM;
            READ_MEM: begin
                if (mem_done) begin
                    next_state = is_write ? REFILL_WRITE : REFILL_READ;
                end
            end
            REFILL_READ,
            REFILL_WRITE: next_state = IDLE;
            default:      next_state = IDLE;
        endcase
    end

    // memory request source, one at a time
    always_comb begin
        mem_issue      = 1'b0;
        mem_next.addr  = fill_addr;
        mem_next.op    = OP_READ;
        mem_next.wdata = '0;
        case (state)
            LOOKUP:    mem_issue = !hit && !victim_dirty;
            READ_CACHE: begin
                if (!hit_q) begin
                    mem_issue      = 1'b1;   // victim line just read out
                    mem_next.addr  = victim_addr;
                    mem_next.op    = OP_WRITE;
                    mem_next.wdata = data_rdata;
                end
            end
            WRITE_MEM: mem_issue = mem_done; // fetch follows the writeback
            default:   mem_issue = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_valid <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            mem_valid <= 1'b0;
        end else if (mem_issue) begin
            mem_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_issue) begin
            mem_req <= mem_next;
        end
    end

    assign req_ready    = (state == IDLE);
    assign tag_rd_en    = req_valid && req_ready;
    assign tag_rd_index = req.addr[LINE_OFFSET_BITS +: IDX_BITS];

    assign tag_wr_en    = (state == WRITE_CACHE) || (state == REFILL_READ)
                       || (state == REFILL_WRITE);
    assign tag_wr_index = req_index;
    assign tag_wr_way   = way_q;

    always_comb begin
        tag_wr_entry.valid = 1'b1;
        tag_wr_entry.dirty = (state != REFILL_READ);   // clean only after a read fill
        tag_wr_entry.tag   = req_tag;
    end

    always_comb begin
        data_en    = 1'b0;
        data_we    = 1'b0;
        data_way   = way_q;
        data_banks = '1;
        data_index = req_index;
        data_wdata = '0;
        data_wmask = '0;
        case (state)
            LOOKUP: begin
                data_en  = hit ? !is_write : victim_dirty;
                data_way = hit ? hit_way : victim_way;
            end
            WRITE_CACHE: begin
                data_en    = 1'b1;
                data_we    = 1'b1;
                data_banks = bank_oh;
                data_wdata = store_data_line;
                data_wmask = store_mask_line;
            end
            REFILL_READ, REFILL_WRITE: begin
                data_en    = 1'b1;
                data_we    = 1'b1;
                data_wdata = (fill_line & ~merge_mask) | (store_data_line & merge_mask);
                data_wmask = '1;
            end
            default: data_en = 1'b0;
        endcase
    end

    always_comb begin
        done  = 1'b0;
        rdata = '0;
        case (state)
            WRITE_CACHE, REFILL_WRITE: done = 1'b1;
            READ_CACHE: begin
                done = hit_q;
                if (hit_q) begin
                    rdata = bank_word(data_rdata, req_bank);
                end
            end
            REFILL_READ: begin
                done  = 1'b1;
                rdata = bank_word(fill_line, req_bank);
            end
            default: done = 1'b0;
        endcase
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     req_ready,
    output logic     done,
    output word_t    rdata,
    output logic     mem_valid,
    output mem_req_t mem_req,
    input  logic     mem_ready,
    input  logic     mem_done,
    input  line_t    mem_rdata
);

    localparam int IDX_BITS = $clog2(NUM_SETS);

    logic                      tag_rd_en;
    logic [IDX_BITS-1:0]       tag_rd_index;
    tag_entry_t [NUM_WAYS-1:0] tag_rd_entries;
    logic                      tag_wr_en;
    logic [IDX_BITS-1:0]       tag_wr_index;
    way_oh_t                   tag_wr_way;
    tag_entry_t                tag_wr_entry;

    logic                      data_en;
    logic                      data_we;
    way_oh_t                   data_way;
    bank_oh_t                  data_banks;
    logic [IDX_BITS-1:0]       data_index;
    line_t                     data_wdata;
    line_t                     data_wmask;
    line_t                     data_rdata;

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (.*);

    dcache_tag_array #(.NUM_SETS(NUM_SETS)) u_tag_array (
        .clock      (clock),
        .reset_n    (reset_n),
        .rd_en      (tag_rd_en),
        .rd_index   (tag_rd_index),
        .rd_entries (tag_rd_entries),
        .wr_en      (tag_wr_en),
        .wr_index   (tag_wr_index),
        .wr_way     (tag_wr_way),
        .wr_entry   (tag_wr_entry)
    );

    dcache_data_array #(.NUM_SETS(NUM_SETS)) u_data_array (
        .clock (clock),
        .en    (data_en),
        .we    (data_we),
        .way   (data_way),
        .banks (data_banks),
        .index (data_index),
        .wdata (data_wdata),
        .wmask (data_wmask),
        .rdata (data_rdata)
    );

endmodule

// File: sim/dcache_asserts.sv
`timescale 1ns/100ps

module dcache_asserts
    import dcache_bus_pkg::*;
(
    input logic     clock,
    input logic     reset_n,
    input logic     req_valid,
    input logic     req_ready,
    input logic     done,
    input logic     mem_valid,
    input mem_req_t mem_req,
    input logic     mem_ready
);

    int failures = 0;

    // memory request held until taken
    mem_req_held: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
        else begin
            failures++;
            $error("mem_valid dropped or mem_req changed before mem_ready");
        end

    busy_after_accept: assert property (@(posedge clock) disable iff (!reset_n)
        req_valid && req_ready |=> !req_ready)
        else begin
            failures++;
            $error("req_ready high in the cycle after acceptance");
        end

    busy_until_done: assert property (@(posedge clock) disable iff (!reset_n)
        !req_ready && !done |=> !req_ready)
        else begin
            failures++;
            $error("req_ready rose before done");
        end

    done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done)
        else begin
            failures++;
            $error("done high for two cycles in a row");
        end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

// File: sim/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam logic [31:0] SEED        = 32'h429e3e81;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;
    localparam word_t       FILL_XOR    = 64'h5a3c_96e1_0f87_d24b;
    localparam int          NUM_RANDOM  = 400;
    localparam int          CYCLE_LIMIT = (NUM_RANDOM + 40) * 20 + 500;

    logic     clock;
    logic     reset_n;
    logic     req_valid;
    cpu_req_t req;
    logic     req_ready;
    logic     done;
    word_t    rdata;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ready;
    logic     mem_done;
    line_t    mem_rdata;

    line_t       lines [256];    // responder memory, 4 tags x 64 sets
    word_t       model [2048];   // flat word model of the same window
    logic [31:0] stim_rng;
    logic [31:0] mem_rng;        // own stream for the responder
    int          errors;
    int          checks;
    int          cycles;
    int          rd_count;
    int          wb_count;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wb_addr;
    line_t       last_wb_line;

    dcache_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw(inout logic [31:0] rng, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], rng[0]};
            rng = lfsr_step(rng);
        end
    endtask

    function automatic logic [TAG_BITS-1:0] tag_of(input int sel);
        case (sel)
            0:       return 20'h00012;
            1:       return 20'h0a5c3;
            2:       return 20'h3f00e;
            default: return 20'h7b1d4;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input int sel, input int idx, input int bank);
        return {tag_of(sel), 6'(idx), 3'(bank), 3'b000};
    endfunction

    // responder slot of a line, -1 outside the tag window
    function automatic int line_key(input logic [31:0] addr);
        for (int s = 0; s < 4; s++) begin
            if (addr[31:12] == tag_of(s)) begin
                return s * 64 + int'(addr[11:6]);
            end
        end
        return -1;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return line_key(addr) * 8 + int'(addr[5:3]);
    endfunction

    function automatic word_t init_word(input logic [31:0] addr);
        return {32'h0, addr} ^ FILL_XOR;
    endfunction

    function automatic line_t model_line(input int key);
        line_t l;
        for (int b = 0; b < 8; b++) begin
            l[b*64 +: 64] = model[key*8 + b];
        end
        return l;
    endfunction

    task automatic step();
        @(posedge clock);
        #10;
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // lat counts edges from acceptance to the edge that samples done
    task automatic access(input bus_op_t op, input logic [31:0] addr, input word_t wdata,
                          input word_t wmask, output word_t rd, output int lat);
        req_valid  = 1'b1;
        req.addr   = addr;
        req.op     = op;
        req.wdata  = wdata;
        req.wmask  = wmask;
        while (!req_ready) step();
        step();
        req_valid = 1'b0;
        lat = 1;
        while (!done) begin
            step();
            lat++;
        end
        rd = rdata;
    endtask

    task automatic write_word(input logic [31:0] addr, input word_t wdata, input word_t wmask);
        word_t rd;
        int    lat;
        access(OP_WRITE, addr, wdata, wmask, rd, lat);
        compare_word("write_rdata", '0, rd);   // no read data on a store
        model[word_index(addr)] = (model[word_index(addr)] & ~wmask) | (wdata & wmask);
    endtask

    task automatic read_and_check(input string name, input logic [31:0] addr, output int lat);
        word_t rd;
        access(OP_READ, addr, '0, '0, rd, lat);
        compare_word(name, model[word_index(addr)], rd);
    endtask

    initial begin : responder
        mem_req_t    mreq;
        logic [63:0] bp;
        int          key;
        forever begin
            step();
            if (mem_valid) begin
                draw(mem_rng, 2, bp);       // 0..3 cycles of back-pressure
                repeat (int'(bp)) step();
                mem_ready = 1'b1;
                mreq = mem_req;
                step();
                mem_ready = 1'b0;
                key = line_key(mreq.addr);
                if (key < 0) begin
                    errors++;
                    $display("memory request to %h lies outside the tag window", mreq.addr);
                end else if (mreq.op == OP_WRITE) begin
                    lines[key]   = mreq.wdata;
                    wb_count++;
                    last_wb_addr = mreq.addr;
                    last_wb_line = mreq.wdata;
                end else begin
                    rd_count++;
                    last_rd_addr = mreq.addr;
                end
                draw(mem_rng, 2, bp);       // done 1..4 cycles after acceptance
                repeat (int'(bp)) step();
                mem_done = 1'b1;
                if (key >= 0 && mreq.op == OP_READ) begin
                    mem_rdata = lines[key];
                end
                step();
                mem_done  = 1'b0;
                mem_rdata = '0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("Testbench failed");
        $display("timeout after %0d cycles, a request never completed", cycles);
        $finish;
    end

    initial begin : main
        word_t       wd;
        word_t       wm;
        logic [63:0] r;
        int          lat;
        int          rd_before;
        int          wb_before;
        int          key;
        int          sel;
        int          idx;
        logic [31:0] addr;

        stim_rng     = SEED;
        mem_rng      = SEED;
        errors       = 0;
        checks       = 0;
        rd_count     = 0;
        wb_count     = 0;
        last_rd_addr = '0;
        last_wb_addr = '0;
        last_wb_line = '0;
        reset_n      = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        mem_ready    = 1'b0;
        mem_done     = 1'b0;
        mem_rdata    = '0;
        for (int k = 0; k < 256; k++) begin
            for (int b = 0; b < 8; b++) begin
                lines[k][b*64 +: 64] = init_word(make_addr(k / 64, k % 64, b));
                model[k*8 + b]       = init_word(make_addr(k / 64, k % 64, b));
            end
        end
        repeat (2) @(posedge clock);
        #10;
        reset_n = 1'b1;

        checks++;
        if (done !== 1'b0 || mem_valid !== 1'b0 || req_ready !== 1'b1) begin
            errors++;
            $display("error after_reset: expected done 0 mem_valid 0 req_ready 1, %s",
                     $sformatf("actual done %b mem_valid %b req_ready %b",
                               done, mem_valid, req_ready));
        end

        // cold read misses and fetches its line
        addr = make_addr(0, 10, 2);
        rd_before = rd_count;
        read_and_check("cold_read", addr, lat);
        checks++;
        if (rd_count != rd_before + 1 || last_rd_addr != {addr[31:6], 6'b0}) begin
            errors++;
            $display("cold_read of %h fetched no line from memory", addr);
        end

        // allocate by write, then a plain hit
        addr = make_addr(1, 11, 5);
        draw(stim_rng, 64, wd);
        draw(stim_rng, 64, wm);
        write_word(addr, wd, wm);
        read_and_check("write_then_read", addr, lat);
        checks++;
        if (lat != 2) begin
            errors++;
            $display("error write_then_read latency: expected 2, actual %0d", lat);
        end

        // three tags into set 12, the last one evicts a dirty way
        wb_before = 0;
        for (int s = 0; s < 3; s++) begin
            draw(stim_rng, 64, wd);
            draw(stim_rng, 64, wm);
            draw(stim_rng, 3, r);
            if (s == 2) wb_before = wb_count;
            write_word(make_addr(s, 12, int'(r)), wd, wm);
        end
        key = line_key(last_wb_addr);
        checks++;
        if (wb_count != wb_before + 1) begin
            errors++;
            $display("third write to set 12 caused no write-back");
        end else if (last_wb_addr != make_addr(0, 12, 0)
                     && last_wb_addr != make_addr(1, 12, 0)) begin
            errors++;
            $display("error eviction_addr: expected %h or %h, actual %h",
                     make_addr(0, 12, 0), make_addr(1, 12, 0), last_wb_addr);
        end else if (last_wb_line !== model_line(key)) begin
            errors++;
            $display("error eviction_line: expected %h, actual %h",
                     model_line(key), last_wb_line);
        end

        // write miss, then every bank of the allocated line
        draw(stim_rng, 64, wd);
        draw(stim_rng, 64, wm);
        write_word(make_addr(3, 13, 4), wd, wm);
        for (int b = 0; b < 8; b++) begin
            read_and_check("allocate_line", make_addr(3, 13, b), lat);
        end

        // random mix over 4 sets and 3 tags
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw(stim_rng, 2, r);
            sel = int'(r) % 3;
            draw(stim_rng, 2, r);
            idx = int'(r);
            draw(stim_rng, 3, r);
            addr = make_addr(sel, idx, int'(r));
            draw(stim_rng, 1, r);
            if (r[0]) begin
                draw(stim_rng, 64, wd);
                draw(stim_rng, 64, wm);
                write_word(addr, wd, wm);
            end else begin
                read_and_check("random_mix", addr, lat);
            end
        end

        step();
        if (errors == 0 && UUT.u_asserts.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_asserts.failures);
        $finish;
    end

endmodule

// File: flist.f
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hw/dcache_cfg_pkg.sv
  - hw/dcache_bus_pkg.sv
  - hw/dcache_tag_array.sv
  - hw/dcache_data_array.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_asserts.sv
      - sim/dcache_tb.sv
